// File: src/norm_cfg_pkg.sv
// Group geometry is fixed at elaboration and NUM_VALUES must be a power of two
package norm_cfg_pkg;

    // Samples carried by one beat
    localparam int LANES = 4;

    // Beats that make up one group
    localparam int NUM_ITERS = 4;

    localparam int NUM_VALUES = LANES * NUM_ITERS;

    // Division by the group size reduces to this shift
    localparam int VALUE_SHIFT = $clog2(NUM_VALUES);

    localparam int ITER_WIDTH = $clog2(NUM_ITERS);

endpackage

// File: src/norm_fmt_pkg.sv
// Samples are signed Q4.4 and the inverse square root table only covers variance indices 0 to 1023
package norm_fmt_pkg;

    import norm_cfg_pkg::*;

    localparam int IN_WIDTH  = 8;
    localparam int IN_FRAC   = 4;
    localparam int OUT_WIDTH = 8;
    localparam int OUT_FRAC  = 4;

    // One extra bit so that x minus the mean cannot overflow
    localparam int DIFF_WIDTH   = IN_WIDTH + 1;
    localparam int SQUARE_WIDTH = 2 * DIFF_WIDTH;
    localparam int SQUARE_FRAC  = 2 * IN_FRAC;

    localparam int ISQRT_WIDTH     = 16;
    localparam int ISQRT_FRAC      = 8;
    localparam int VAR_INDEX_WIDTH = 10;

    typedef logic signed [IN_WIDTH-1:0]   sample_t;
    typedef logic signed [DIFF_WIDTH-1:0] diff_t;
    typedef logic [SQUARE_WIDTH-1:0]      square_t;
    typedef logic [ISQRT_WIDTH-1:0]       isqrt_t;

    typedef sample_t [LANES-1:0] in_beat_t;
    typedef diff_t   [LANES-1:0] diff_beat_t;
    typedef square_t [LANES-1:0] square_beat_t;

    typedef isqrt_t isqrt_table_t [2**VAR_INDEX_WIDTH];

    // Entry v is 2^ISQRT_FRAC / sqrt(v / 2^SQUARE_FRAC), computed as an integer root
    // of 2^(2*ISQRT_FRAC + SQUARE_FRAC) / v so no real arithmetic is needed
    function automatic isqrt_table_t build_isqrt_table();
        isqrt_table_t      table_out;
        longint unsigned   target;
        longint unsigned   root;
        longint unsigned   trial;
        longint unsigned   isqrt_max;
        isqrt_max = (64'd1 << ISQRT_WIDTH) - 1;
        table_out[0] = isqrt_t'(isqrt_max);
        for (int v = 1; v < 2**VAR_INDEX_WIDTH; v++) begin
            target = (64'd1 << (2 * ISQRT_FRAC + SQUARE_FRAC)) / v;
            root = 0;
            // Bit by bit square root
            for (int b = ISQRT_WIDTH; b >= 0; b--) begin
                trial = root | (64'd1 << b);
                if (trial * trial <= target) begin
                    root = trial;
                end
            end
            if (root > isqrt_max) begin
                table_out[v] = isqrt_t'(isqrt_max);
            end else begin
                table_out[v] = isqrt_t'(root);
            end
        end
        return table_out;
    endfunction

endpackage

// File: src/norm_stream_if.sv
// Payload type is chosen per instance and data and last must hold until the beat transfers
`timescale 1ns/100ps

interface norm_stream_if #(
    parameter type payload_t = logic
) (
    input logic clk
);

    logic     valid;
    logic     ready;
    payload_t data;
    // High on the final beat of a group
    logic     last;

    modport src (
        input  clk,
        input  ready,
        output valid,
        output data,
        output last
    );

    modport snk (
        input  clk,
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

// File: src/beat_fifo.sv
// DEPTH must be a power of two so that the pointers wrap on their own
`timescale 1ns/100ps

module beat_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 8
) (
    input logic        clk,
    input logic        rst_n,
    norm_stream_if.snk wr,
    norm_stream_if.src rd
);

    localparam int PTR_WIDTH = $clog2(DEPTH);

    // Payload and last are kept side by side
    payload_t             mem_data [DEPTH];
    logic                 mem_last [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 do_wr;
    logic                 do_rd;

    assign wr.ready = (count != (PTR_WIDTH + 1)'(DEPTH));
    assign do_wr    = wr.valid && wr.ready;
    assign do_rd    = rd.valid && rd.ready;

    assign rd.valid = (count != '0);
    assign rd.data  = mem_data[rd_ptr];
    assign rd.last  = mem_last[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_data[wr_ptr] <= wr.data;
            mem_last[wr_ptr] <= wr.last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/lane_moment_acc.sv
// ACC_WIDTH must hold the sum of a whole group and the moment is a floor division by NUM_VALUES
`timescale 1ns/100ps

module lane_moment_acc #(
    parameter int IN_WIDTH  = 8,
    parameter bit SIGNED_IN = 1'b1,
    parameter int LANES     = 4,
    parameter int ACC_WIDTH = 12
) (
    input logic        clk,
    input logic        rst_n,
    norm_stream_if.snk beat_in,
    norm_stream_if.src moment_out
);

    import norm_cfg_pkg::*;

    logic [ACC_WIDTH-1:0] acc;
    logic [ACC_WIDTH-1:0] beat_sum;
    logic [ACC_WIDTH-1:0] total;
    logic [ACC_WIDTH-1:0] moment_c;
    logic [ACC_WIDTH-1:0] moment_q;
    logic                 moment_valid;
    logic                 take_beat;

    // Input stalls while a finished moment waits
    assign beat_in.ready = !moment_valid;
    assign take_beat     = beat_in.valid && beat_in.ready;

    assign moment_out.valid = moment_valid;
    assign moment_out.data  = moment_q;
    assign moment_out.last  = 1'b1;

    // Lane reduction with optional sign extension
    always_comb begin
        logic ext_bit;
        beat_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            ext_bit  = SIGNED_IN && beat_in.data[i][IN_WIDTH-1];
            beat_sum = beat_sum + {{(ACC_WIDTH - IN_WIDTH){ext_bit}}, beat_in.data[i]};
        end
    end

    always_comb begin
        total = acc + beat_sum;
        if (SIGNED_IN) begin
            moment_c = $signed(total) >>> VALUE_SHIFT;
        end else begin
            moment_c = total >> VALUE_SHIFT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc          <= '0;
            moment_valid <= 1'b0;
        end else if (take_beat) begin
            if (beat_in.last) begin
                acc          <= '0;
                moment_valid <= 1'b1;
            end else begin
                acc <= total;
            end
        end else if (moment_out.ready) begin
            moment_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_beat && beat_in.last) begin
            moment_q <= moment_c;
        end
    end

endmodule

// File: src/center_square.sv
// The mean of a group must arrive before the first beat of that group can pass
`timescale 1ns/100ps

module center_square (
    input logic        clk,
    input logic        rst_n,
    norm_stream_if.snk mean_in,
    norm_stream_if.snk beat_in,
    norm_stream_if.src diff_out,
    norm_stream_if.src square_out
);

    import norm_cfg_pkg::*;
    import norm_fmt_pkg::*;

    sample_t      mean_q;
    logic         mean_held;
    diff_beat_t   diff_c;
    square_beat_t square_c;
    diff_beat_t   diff_q;
    square_beat_t square_q;
    logic         last_q;
    logic         out_valid;
    logic         advance;
    logic         take_beat;

    // Stage moves only when both consumers can take the beat
    assign advance   = !out_valid || (diff_out.ready && square_out.ready);
    assign take_beat = beat_in.valid && beat_in.ready;

    assign mean_in.ready = !mean_held;
    assign beat_in.ready = mean_held && advance;

    // Split so neither branch takes a beat the other one refuses
    assign diff_out.valid   = out_valid && square_out.ready;
    assign square_out.valid = out_valid && diff_out.ready;
    assign diff_out.data    = diff_q;
    assign diff_out.last    = last_q;
    assign square_out.data  = square_q;
    assign square_out.last  = last_q;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            diff_c[i]   = diff_t'($signed(beat_in.data[i])) - diff_t'(mean_q);
            square_c[i] = $signed(diff_c[i]) * $signed(diff_c[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mean_held <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (mean_in.valid && mean_in.ready) begin
                mean_held <= 1'b1;
            end else if (take_beat && beat_in.last) begin
                mean_held <= 1'b0;
            end
            if (take_beat) begin
                out_valid <= 1'b1;
            end else if (advance) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mean_in.valid && mean_in.ready) begin
            mean_q <= sample_t'(mean_in.data);
        end
        if (take_beat) begin
            diff_q   <= diff_c;
            square_q <= square_c;
            last_q   <= beat_in.last;
        end
    end

endmodule

// File: src/isqrt_unit.sv
// Variance index saturates at 1023 and each result is repeated for exactly NUM_ITERS transfers
`timescale 1ns/100ps

module isqrt_unit #(
    parameter int NUM_ITERS = norm_cfg_pkg::NUM_ITERS
) (
    input logic        clk,
    input logic        rst_n,
    norm_stream_if.snk var_in,
    norm_stream_if.src isqrt_out
);

    import norm_cfg_pkg::*;
    import norm_fmt_pkg::*;

    localparam isqrt_table_t ISQRT_TABLE = build_isqrt_table();
    localparam int VAR_MAX = 2**VAR_INDEX_WIDTH - 1;

    logic [VAR_INDEX_WIDTH-1:0] index_c;
    logic [VAR_INDEX_WIDTH-1:0] index_q;
    logic                       index_valid;
    isqrt_t                     isqrt_q;
    logic                       isqrt_valid;
    logic [ITER_WIDTH-1:0]      rep_cnt;
    logic                       rep_done;
    logic                       take_var;
    logic                       give_isqrt;

    // Large variances all map to the last table entry
    assign index_c = (var_in.data > VAR_MAX) ? VAR_INDEX_WIDTH'(VAR_MAX)
                                             : var_in.data[VAR_INDEX_WIDTH-1:0];

    // Only one variance in flight until its last repeat is taken
    assign var_in.ready = !index_valid && !isqrt_valid;
    assign take_var     = var_in.valid && var_in.ready;
    assign give_isqrt   = isqrt_out.valid && isqrt_out.ready;
    assign rep_done     = (rep_cnt == ITER_WIDTH'(NUM_ITERS - 1));

    assign isqrt_out.valid = isqrt_valid;
    assign isqrt_out.data  = isqrt_q;
    assign isqrt_out.last  = rep_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            index_valid <= 1'b0;
            isqrt_valid <= 1'b0;
            rep_cnt     <= '0;
        end else begin
            index_valid <= take_var;
            if (index_valid) begin
                isqrt_valid <= 1'b1;
            end else if (give_isqrt && rep_done) begin
                isqrt_valid <= 1'b0;
            end
            if (give_isqrt) begin
                rep_cnt <= rep_done ? '0 : rep_cnt + 1'b1;
            end
        end
    end

    // Clamp then table read
    always_ff @(posedge clk) begin
        if (take_var) begin
            index_q <= index_c;
        end
        if (index_valid) begin
            isqrt_q <= ISQRT_TABLE[index_q];
        end
    end

endmodule

// File: src/scale_cast.sv
// Output is floor-rounded and saturated and the inverse square root must cover the whole group
`timescale 1ns/100ps

module scale_cast #(
    parameter int LANES     = norm_cfg_pkg::LANES,
    parameter int OUT_WIDTH = norm_fmt_pkg::OUT_WIDTH
) (
    input logic        clk,
    input logic        rst_n,
    norm_stream_if.snk diff_in,
    norm_stream_if.snk isqrt_in,
    norm_stream_if.src norm_out
);

    import norm_fmt_pkg::*;

    // Product has IN_FRAC + ISQRT_FRAC fractional bits
    localparam int PROD_WIDTH = DIFF_WIDTH + ISQRT_WIDTH + 1;
    localparam int CAST_SHIFT = IN_FRAC + ISQRT_FRAC - OUT_FRAC;
    localparam logic signed [PROD_WIDTH-1:0] SAT_MAX = (1 <<< (OUT_WIDTH - 1)) - 1;
    localparam logic signed [PROD_WIDTH-1:0] SAT_MIN = -(1 <<< (OUT_WIDTH - 1));

    logic signed [PROD_WIDTH-1:0]    scaled [LANES];
    logic [LANES-1:0][OUT_WIDTH-1:0] res_c;
    logic [LANES-1:0][OUT_WIDTH-1:0] res_q;
    logic                            last_q;
    logic                            out_valid;
    logic                            advance;
    logic                            fire;

    assign advance = !out_valid || norm_out.ready;
    assign fire    = diff_in.valid && isqrt_in.valid && advance;

    // Join of the diff and inverse square root streams
    assign diff_in.ready  = isqrt_in.valid && advance;
    assign isqrt_in.ready = diff_in.valid && advance;

    assign norm_out.valid = out_valid;
    assign norm_out.data  = res_q;
    assign norm_out.last  = last_q;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            // Arithmetic shift gives floor rounding
            scaled[i] = ($signed(diff_in.data[i]) * $signed({1'b0, isqrt_in.data})) >>> CAST_SHIFT;
            if (scaled[i] > SAT_MAX) begin
                res_c[i] = SAT_MAX[OUT_WIDTH-1:0];
            end else if (scaled[i] < SAT_MIN) begin
                res_c[i] = SAT_MIN[OUT_WIDTH-1:0];
            end else begin
                res_c[i] = scaled[i][OUT_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (fire) begin
            out_valid <= 1'b1;
        end else if (advance) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_q  <= res_c;
            last_q <= diff_in.last;
        end
    end

endmodule

// File: src/group_norm_2d.sv
// LANES, NUM_ITERS, IN_WIDTH and OUT_WIDTH must equal the package values that fix the beat types
`timescale 1ns/100ps

module group_norm_2d #(
    parameter int LANES     = norm_cfg_pkg::LANES,
    parameter int NUM_ITERS = norm_cfg_pkg::NUM_ITERS,
    parameter int IN_WIDTH  = norm_fmt_pkg::IN_WIDTH,
    parameter int OUT_WIDTH = norm_fmt_pkg::OUT_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [LANES*IN_WIDTH-1:0]  in_data,
    input  logic                       in_last,
    input  logic                       in_valid,
    output logic                       in_ready,
    output logic [LANES*OUT_WIDTH-1:0] out_data,
    output logic                       out_last,
    output logic                       out_valid,
    input  logic                       out_ready
);

    import norm_fmt_pkg::*;

    // Sum growth over the lanes and the beats of a group
    localparam int SUM_GROWTH     = $clog2(LANES) + $clog2(NUM_ITERS);
    localparam int MEAN_ACC_WIDTH = IN_WIDTH + SUM_GROWTH;
    localparam int VAR_ACC_WIDTH  = SQUARE_WIDTH + SUM_GROWTH;
    // Room for the next group while the current one is normalized
    localparam int FIFO_DEPTH     = 2 * NUM_ITERS;

    norm_stream_if #(.payload_t(in_beat_t))                    in_fifo_wr (.clk(clk));
    norm_stream_if #(.payload_t(in_beat_t))                    in_fifo_rd (.clk(clk));
    norm_stream_if #(.payload_t(in_beat_t))                    mean_beat  (.clk(clk));
    norm_stream_if #(.payload_t(logic [MEAN_ACC_WIDTH-1:0]))   mean_if    (.clk(clk));
    norm_stream_if #(.payload_t(diff_beat_t))                  diff_wr    (.clk(clk));
    norm_stream_if #(.payload_t(diff_beat_t))                  diff_rd    (.clk(clk));
    norm_stream_if #(.payload_t(square_beat_t))                square_if  (.clk(clk));
    norm_stream_if #(.payload_t(logic [VAR_ACC_WIDTH-1:0]))    var_if     (.clk(clk));
    norm_stream_if #(.payload_t(isqrt_t))                      isqrt_if   (.clk(clk));
    norm_stream_if #(.payload_t(logic [LANES*OUT_WIDTH-1:0]))  norm_if    (.clk(clk));

    // Input split to the FIFO and the mean accumulator
    assign in_fifo_wr.data  = in_data;
    assign in_fifo_wr.last  = in_last;
    assign in_fifo_wr.valid = in_valid && mean_beat.ready;
    assign mean_beat.data   = in_data;
    assign mean_beat.last   = in_last;
    assign mean_beat.valid  = in_valid && in_fifo_wr.ready;
    assign in_ready         = in_fifo_wr.ready && mean_beat.ready;

    assign out_data      = norm_if.data;
    assign out_last      = norm_if.last;
    assign out_valid     = norm_if.valid;
    assign norm_if.ready = out_ready;

    beat_fifo #(
        .payload_t (in_beat_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_in_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (in_fifo_wr),
        .rd    (in_fifo_rd)
    );

    // First pass
    lane_moment_acc #(
        .IN_WIDTH  (IN_WIDTH),
        .SIGNED_IN (1'b1),
        .LANES     (LANES),
        .ACC_WIDTH (MEAN_ACC_WIDTH)
    ) u_mean_acc (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_in    (mean_beat),
        .moment_out (mean_if)
    );

    center_square u_center (
        .clk        (clk),
        .rst_n      (rst_n),
        .mean_in    (mean_if),
        .beat_in    (in_fifo_rd),
        .diff_out   (diff_wr),
        .square_out (square_if)
    );

    beat_fifo #(
        .payload_t (diff_beat_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_diff_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (diff_wr),
        .rd    (diff_rd)
    );

    // Second pass over the squares
    lane_moment_acc #(
        .IN_WIDTH  (SQUARE_WIDTH),
        .SIGNED_IN (1'b0),
        .LANES     (LANES),
        .ACC_WIDTH (VAR_ACC_WIDTH)
    ) u_var_acc (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_in    (square_if),
        .moment_out (var_if)
    );

    isqrt_unit #(
        .NUM_ITERS (NUM_ITERS)
    ) u_isqrt (
        .clk       (clk),
        .rst_n     (rst_n),
        .var_in    (var_if),
        .isqrt_out (isqrt_if)
    );

    scale_cast #(
        .LANES     (LANES),
        .OUT_WIDTH (OUT_WIDTH)
    ) u_scale (
        .clk      (clk),
        .rst_n    (rst_n),
        .diff_in  (diff_rd),
        .isqrt_in (isqrt_if),
        .norm_out (norm_if)
    );

endmodule

// File: verif/norm_checker.sv
// Expected beats must arrive in input order and every handshake is sampled on the falling clock edge
`timescale 1ns/100ps

module norm_checker #(
    parameter int LANES     = norm_cfg_pkg::LANES,
    parameter int NUM_ITERS = norm_cfg_pkg::NUM_ITERS,
    parameter int OUT_WIDTH = norm_fmt_pkg::OUT_WIDTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic                       in_ready,
    input  logic [LANES*OUT_WIDTH-1:0] exp_data,
    input  logic [LANES*OUT_WIDTH-1:0] out_data,
    input  logic                       out_last,
    input  logic                       out_valid,
    input  logic                       out_ready,
    output int                         error_count,
    output int                         beats_seen,
    output int                         groups_ok,
    output int                         groups_bad
);

    logic [LANES*OUT_WIDTH-1:0] exp_q [$];
    int                         beat_in_group;
    int                         group_idx;
    int                         group_errors;

    function automatic string group_name(input int g);
        case (g)
            0:       return "constant samples";
            1:       return "mean shift";
            2:       return "variance clamp";
            3:       return "saturation";
            4:       return "stalled group a";
            5:       return "stalled group b";
            default: return "unexpected group";
        endcase
    endfunction

    task automatic check_beat();
        logic [LANES*OUT_WIDTH-1:0] expected;
        logic [OUT_WIDTH-1:0]       exp_lane;
        logic [OUT_WIDTH-1:0]       got_lane;
        logic                       exp_last;
        // Last is expected on every NUM_ITERS-th output beat
        exp_last = (beat_in_group == NUM_ITERS - 1);
        if (exp_q.size() == 0) begin
            $display("Time %0t: an output beat arrived with no input beat left to match it", $time);
            error_count++;
            group_errors++;
        end else begin
            expected = exp_q.pop_front();
            for (int i = 0; i < LANES; i++) begin
                exp_lane = expected[i*OUT_WIDTH +: OUT_WIDTH];
                got_lane = out_data[i*OUT_WIDTH +: OUT_WIDTH];
                if (got_lane !== exp_lane) begin
                    $display("[ERROR] %0t out_data lane %0d expected 0x%h got 0x%h",
                             $time, i, exp_lane, got_lane);
                    error_count++;
                    group_errors++;
                end
            end
        end
        if (out_last !== exp_last) begin
            $display("[ERROR] %0t out_last expected %0b got %0b", $time, exp_last, out_last);
            error_count++;
            group_errors++;
        end
        beats_seen++;
        if (exp_last) begin
            if (group_errors == 0) begin
                groups_ok++;
                $display("Group %0d (%s): ok", group_idx, group_name(group_idx));
            end else begin
                groups_bad++;
                $display("Group %0d (%s): %0d mismatches", group_idx, group_name(group_idx),
                         group_errors);
            end
            group_idx++;
            group_errors  = 0;
            beat_in_group = 0;
        end else begin
            beat_in_group++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            error_count   = 0;
            beats_seen    = 0;
            groups_ok     = 0;
            groups_bad    = 0;
            beat_in_group = 0;
            group_idx     = 0;
            group_errors  = 0;
        end else begin
            if (in_valid && in_ready) begin
                exp_q.push_back(exp_data);
            end
            if (out_valid && out_ready) begin
                check_beat();
            end
        end
    end

endmodule

// File: verif/tb_group_norm.sv
// Run from the project root so the tests file is found, which holds six groups of 8-bit samples
`timescale 1ns/100ps

module tb_group_norm;

    import norm_cfg_pkg::*;
    import norm_fmt_pkg::*;

    localparam int    NUM_GROUPS     = 6;
    localparam int    NUM_BEATS      = NUM_GROUPS * NUM_ITERS;
    localparam int    WORD_WIDTH     = 8;
    localparam int    WORDS_PER_BEAT = 2 * LANES;
    localparam int    TIMEOUT_CYCLES = 40 * NUM_BEATS + 100;
    localparam string TESTS_FILE     = "verif/group_norm_tests.txt";

    logic                       clk;
    logic                       rst_n;
    logic [LANES*IN_WIDTH-1:0]  in_data;
    logic                       in_last;
    logic                       in_valid;
    logic                       in_ready;
    logic [LANES*OUT_WIDTH-1:0] out_data;
    logic                       out_last;
    logic                       out_valid;
    logic                       out_ready;
    logic [LANES*OUT_WIDTH-1:0] exp_data;

    logic [WORD_WIDTH-1:0] tests_mem [NUM_BEATS*WORDS_PER_BEAT];

    int     error_count;
    int     beats_seen;
    int     groups_ok;
    int     groups_bad;
    int     cycle_count;
    integer seed;

    group_norm_2d #(
        .LANES     (LANES),
        .NUM_ITERS (NUM_ITERS),
        .IN_WIDTH  (IN_WIDTH),
        .OUT_WIDTH (OUT_WIDTH)
    ) u_group_norm_2d (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    norm_checker #(
        .LANES     (LANES),
        .NUM_ITERS (NUM_ITERS),
        .OUT_WIDTH (OUT_WIDTH)
    ) u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .exp_data    (exp_data),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .error_count (error_count),
        .beats_seen  (beats_seen),
        .groups_ok   (groups_ok),
        .groups_bad  (groups_bad)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Present one beat and hold it until the DUT takes it
    task automatic send_beat(input int b);
        logic accepted;
        for (int i = 0; i < LANES; i++) begin
            in_data[i*IN_WIDTH +: IN_WIDTH]    = tests_mem[b*WORDS_PER_BEAT + i];
            exp_data[i*OUT_WIDTH +: OUT_WIDTH] = tests_mem[b*WORDS_PER_BEAT + LANES + i];
        end
        in_last  = ((b % NUM_ITERS) == NUM_ITERS - 1);
        in_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
        end
        #1;
    endtask

    // Random back-pressure with ready about three cycles in four
    initial begin
        seed      = 32'h7e1415f4;
        out_ready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            out_ready = (($random(seed) & 3) != 0);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles: output went missing, %0d of %0d beats arrived",
                     cycle_count, beats_seen, NUM_BEATS);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        cycle_count = 0;
        rst_n       = 1'b0;
        in_data     = '0;
        in_last     = 1'b0;
        in_valid    = 1'b0;
        exp_data    = '0;
        $readmemh(TESTS_FILE, tests_mem);
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int b = 0; b < NUM_BEATS; b++) begin
            send_beat(b);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;

        while (beats_seen < NUM_BEATS) begin
            @(posedge clk);
        end
        // Quiet period so an extra or repeated beat still gets caught
        repeat (4 * NUM_ITERS) @(posedge clk);

        $display("Summary: %0d groups ok, %0d groups with errors, %0d beats checked, %0d errors",
                 groups_ok, groups_bad, beats_seen, error_count);
        if (error_count == 0 && beats_seen == NUM_BEATS) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verif/group_norm_tests.txt
// One beat per line: input lanes 0 to 3, then expected output lanes 0 to 3
// Signed Q4.4 samples in hex, four lines per group
// Group 0 constant samples, variance 0
e8 e8 e8 e8 00 00 00 00
e8 e8 e8 e8 00 00 00 00
e8 e8 e8 e8 00 00 00 00
e8 e8 e8 e8 00 00 00 00
// Group 1 mean 20, variance 320, table 228
fc 0c 1c 2c ea f8 07 15
2c 1c 0c fc 15 07 f8 ea
0c fc 2c 1c f8 ea 15 07
1c 2c fc 0c 07 15 ea f8
// Group 2 mean -1, variance clamped to 1023, table 128
7f 80 7f 80 40 c0 40 c0
80 7f 80 7f c0 40 c0 40
7f 80 7f 80 40 c0 40 c0
80 7f 80 7f c0 40 c0 40
// Group 3 mean 16, variance 0, outputs saturate
12 10 10 10 7f 00 00 00
10 0e 10 10 00 80 00 00
10 10 11 10 00 00 7f 00
0f 10 10 10 80 00 00 00
// Group 4 mean -5 after floor, variance 212, table 281
f0 f8 00 08 f3 fc 05 0e
e0 f0 10 20 e2 f3 17 28
ff 01 fd 03 04 06 02 08
f1 f2 f3 f4 f5 f6 f7 f8
// Group 5 mean 32, variance 256, table 256
30 10 30 10 10 f0 10 f0
10 30 10 30 f0 10 f0 10
30 30 10 10 10 10 f0 f0
10 10 30 30 f0 f0 10 10

// File: list.f
src/norm_cfg_pkg.sv
src/norm_fmt_pkg.sv
src/norm_stream_if.sv
src/beat_fifo.sv
src/lane_moment_acc.sv
src/center_square.sv
src/isqrt_unit.sv
src/scale_cast.sv
src/group_norm_2d.sv
verif/norm_checker.sv
verif/tb_group_norm.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_group_norm
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
